//--- count_down.sv
`timescale 1ns/100ps
`default_nettype none

module count_down import ln_pkg::*; (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  start,
    output logic done
);

    count_state_e        state;
    logic [sd_cnt_w-1:0] cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
            cnt   <= '0;
        end else if (start) begin
            // Restart also while a count is running
            state <= counting;
            cnt   <= sd_cnt_w'(sd_total_latency - 1);
        end else if (state == counting) begin
            if (cnt == '0) begin
                state <= idle;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    assign done = (state == counting) && (cnt == '0);

endmodule

`default_nettype wire

//--- fp16_to_int_sat.sv
`timescale 1ns/100ps
`default_nettype none

module fp16_to_int_sat import ln_pkg::*; (
    input  wire fp16_t        a,
    output logic signed [7:0] q
);

    logic signed [6:0] e;
    logic [10:0]       shifted;
    logic [7:0]        mag;

    always_comb begin
        e       = 7'(a.exp) - 7'(fp16_bias);
        // Dropping the fraction bits truncates toward zero
        shifted = {1'b1, a.mant} >> (7'sd10 - e);
        mag     = shifted[7:0];

        if (a.exp == '0 || e < 0) begin
            q = 8'sd0;
        end else if (e >= 7) begin
            // Magnitude 128 or more
            q = a.sign ? 8'sh80 : 8'sh7f;
        end else if (a.sign) begin
            q = -$signed(mag);
        end else begin
            q = $signed(mag);
        end
    end

endmodule

`default_nettype wire

//--- gamma_path.sv
`timescale 1ns/100ps
`default_nettype none

module gamma_path import ln_pkg::*; (
    input  wire               clk,
    input  wire               rst_n,
    input  wire fp16_t        gamma_scaled,
    input  wire signed [7:0]  xd,
    input  wire [15:0]        sd,
    input  wire               sd_valid,
    input  wire               flop,
    input  wire ln_cs_t       cs_in,
    output logic              rsqrt_done,
    output logic signed [7:0] y,
    output ln_cs_t            cs_out
);

    fp16_t sd_fp;
    fp16_t sd_fp_q;
    fp16_t rsqrt_sd;
    fp16_t rsqrt_sd_q;
    logic  capture;

    fp16_t             scale;
    fp16_t             scale_q;
    fp16_t             xd_fp;
    fp16_t             xd_fp_q;
    fp16_t             prod;
    fp16_t             prod_q;
    logic signed [7:0] y_sat;

    ln_cs_t cs_q [cs_latency-1];

    ////////////////////
    // rsqrt(sd), held per vector
    ////////////////////
    int_to_fp16 i_sd_to_fp (
        .a (17'({1'b0, sd})),
        .q (sd_fp)
    );

    rsqrt_fp16 i_rsqrt (
        .clk   (clk),
        .rst_n (rst_n),
        .a     (sd_fp_q),
        .q     (rsqrt_sd)
    );

    count_down i_count_down (
        .clk   (clk),
        .rst_n (rst_n),
        .start (sd_valid),
        .done  (capture)
    );

    // A new sd takes priority over a pending capture
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sd_fp_q    <= '0;
            rsqrt_sd_q <= '0;
            rsqrt_done <= 1'b0;
        end else if (sd_valid) begin
            sd_fp_q    <= sd_fp;
            rsqrt_done <= 1'b0;
        end else if (capture) begin
            rsqrt_sd_q <= rsqrt_sd;
            rsqrt_done <= 1'b1;
        end
    end

    ////////////////////
    // Element pipeline
    ////////////////////
    mult_fp16 i_mult_scale (
        .a (gamma_scaled),
        .b (rsqrt_sd_q),
        .q (scale)
    );

    int_to_fp16 i_xd_to_fp (
        .a ({{9{xd[7]}}, xd}),
        .q (xd_fp)
    );

    mult_fp16 i_mult_xd (
        .a (xd_fp_q),
        .b (scale_q),
        .q (prod)
    );

    fp16_to_int_sat i_y_sat (
        .a (prod_q),
        .q (y_sat)
    );

    // Every stage holds while flop is low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scale_q <= '0;
            xd_fp_q <= '0;
            prod_q  <= '0;
            y       <= '0;
        end else if (flop) begin
            scale_q <= scale;
            xd_fp_q <= xd_fp;
            prod_q  <= prod;
            y       <= y_sat;
        end
    end

    // Control word lines up with y, and reads zero on idle cycles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < cs_latency - 1; i++) begin
                cs_q[i] <= '0;
            end
            cs_out <= '0;
        end else if (flop) begin
            cs_q[0] <= cs_in;
            for (int i = 1; i < cs_latency - 1; i++) begin
                cs_q[i] <= cs_q[i-1];
            end
            cs_out <= cs_q[cs_latency-2];
        end else begin
            cs_out <= '0;
        end
    end

endmodule

`default_nettype wire

//--- gamma_table.sv
`timescale 1ns/100ps
`default_nettype none

module gamma_table import ln_pkg::*; (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                we,
    input  wire [ln_idx_w-1:0] waddr,
    input  wire fp16_t         wdata,
    input  wire [ln_idx_w-1:0] raddr,
    output fp16_t              rdata
);

    fp16_t mem [ln_vec_len];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < ln_vec_len; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Read port sees the entering element index
    assign rdata = mem[raddr];

endmodule

`default_nettype wire

//--- int_to_fp16.sv
`timescale 1ns/100ps
`default_nettype none

module int_to_fp16 import ln_pkg::*; (
    input  wire signed [16:0] a,
    output fp16_t             q
);

    logic [16:0] mag;
    logic [16:0] norm;
    logic [4:0]  lead;
    logic        rnd;
    logic [15:0] em;

    always_comb begin
        mag  = a[16] ? -a : a;
        // Leading one detector
        lead = '0;
        for (int i = 0; i < 17; i++) begin
            if (mag[i]) begin
                lead = 5'(i);
            end
        end
        norm = mag << (5'd16 - lead);
        // Nearest even on the six dropped bits
        rnd  = norm[5] & ((|norm[4:0]) | norm[6]);
        // Mantissa carry ripples into the exponent field
        em   = {6'(fp16_bias + lead), norm[15:6]} + 16'(rnd);
    end

    always_comb begin
        if (mag == '0) begin
            q = '0;
        end else if (em[15:10] >= 6'd31) begin
            q = {a[16], fp16_max_mag};
        end else begin
            q = {a[16], em[14:0]};
        end
    end

endmodule

`default_nettype wire

//--- layer_norm_out.sv
`timescale 1ns/100ps
`default_nettype none

module layer_norm_out import ln_pkg::*; (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                gamma_we,
    input  wire [ln_idx_w-1:0] gamma_waddr,
    input  wire fp16_t         gamma_wdata,
    input  wire [15:0]         sd,
    input  wire                sd_valid,
    input  wire signed [7:0]   xd,
    input  wire ln_cs_t        cs_in,
    input  wire                flop,
    output logic               rsqrt_done,
    output logic signed [7:0]  y,
    output ln_cs_t             cs_out
);

    fp16_t gamma_rd;

    gamma_table i_gamma_table (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (gamma_we),
        .waddr (gamma_waddr),
        .wdata (gamma_wdata),
        .raddr (cs_in.idx),
        .rdata (gamma_rd)
    );

    gamma_path i_gamma_path (
        .clk          (clk),
        .rst_n        (rst_n),
        .gamma_scaled (gamma_rd),
        .xd           (xd),
        .sd           (sd),
        .sd_valid     (sd_valid),
        .flop         (flop),
        .cs_in        (cs_in),
        .rsqrt_done   (rsqrt_done),
        .y            (y),
        .cs_out       (cs_out)
    );

endmodule

`default_nettype wire

//--- layer_norm_properties.sv
`timescale 1ns/100ps
`default_nettype none

module layer_norm_properties import ln_pkg::*; (
    input wire         clk,
    input wire         rst_n,
    input wire         flop,
    input wire         sd_valid,
    input wire         rsqrt_done,
    input wire ln_cs_t cs_out
);

    // Idle edge clears the control word
    a_cs_idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
        !flop |=> cs_out == '0)
        else $error("cs_out not zero after an edge with flop low");

    a_done_falls: assert property (@(posedge clk) disable iff (!rst_n)
        sd_valid |=> !rsqrt_done)
        else $error("rsqrt_done still high after sd_valid");

endmodule

bind layer_norm_out layer_norm_properties u_properties (
    .clk        (clk),
    .rst_n      (rst_n),
    .flop       (flop),
    .sd_valid   (sd_valid),
    .rsqrt_done (rsqrt_done),
    .cs_out     (cs_out)
);

`default_nettype wire

//--- ln_pkg.sv
`default_nettype none

package ln_pkg;

    localparam int ln_idx_w = 8;
    localparam int ln_vec_len = 256;

    // Pipeline depths in clock cycles or flop advances
    localparam int rsqrt_latency = 7;
    localparam int sd_total_latency = 1 + rsqrt_latency + 1;
    localparam int sd_cnt_w = $clog2(sd_total_latency);
    localparam int cs_latency = 3;

    localparam int fp16_bias = 15;
    // Largest finite magnitude, used for every overflow clamp
    localparam logic [14:0] fp16_max_mag = 15'h7bff;

    typedef struct packed {
        logic       sign;
        logic [4:0] exp;
        logic [9:0] mant;
    } fp16_t;

    typedef struct packed {
        logic                store_y;
        logic [ln_idx_w-1:0] idx;
    } ln_cs_t;

    typedef enum logic {
        idle,
        counting
    } count_state_e;

    // 1/sqrt(x) seeds in Q1.15 taken at the start of each segment
    // Entries 0..15 cover x in [1,2), entries 16..31 cover x in [2,4)
    localparam logic [15:0] rsqrt_seed [32] = '{
        16'd32768, 16'd31790, 16'd30894, 16'd30070, 16'd29309, 16'd28602, 16'd27945, 16'd27330,
        16'd26755, 16'd26214, 16'd25705, 16'd25225, 16'd24770, 16'd24339, 16'd23930, 16'd23541,
        16'd23170, 16'd22479, 16'd21845, 16'd21263, 16'd20724, 16'd20225, 16'd19760, 16'd19325,
        16'd18919, 16'd18536, 16'd18176, 16'd17837, 16'd17515, 16'd17211, 16'd16921, 16'd16646
    };

endpackage

`default_nettype wire

//--- mult_fp16.sv
`timescale 1ns/100ps
`default_nettype none

module mult_fp16 import ln_pkg::*; (
    input  wire fp16_t a,
    input  wire fp16_t b,
    output fp16_t      q
);

    logic              sign;
    logic [21:0]       prod;
    logic [9:0]        mant;
    logic              guard;
    logic              sticky;
    logic [10:0]       mant_r;
    logic signed [7:0] exp;

    always_comb begin
        sign = a.sign ^ b.sign;
        prod = {1'b1, a.mant} * {1'b1, b.mant};
        exp  = 8'(a.exp) + 8'(b.exp) - 8'(fp16_bias);

        // Product of two 1.x values lies in [1,4)
        if (prod[21]) begin
            mant   = prod[20:11];
            guard  = prod[10];
            sticky = |prod[9:0];
            exp    = exp + 8'sd1;
        end else begin
            mant   = prod[19:10];
            guard  = prod[9];
            sticky = |prod[8:0];
        end

        mant_r = {1'b0, mant} + 11'(guard & (sticky | mant[0]));
        // All ones rounded up, mantissa field wraps to zero
        if (mant_r[10]) begin
            exp = exp + 8'sd1;
        end

        if (a.exp == '0 || b.exp == '0 || exp <= 0) begin
            q = {sign, 15'd0};
        end else if (exp >= 31) begin
            q = {sign, fp16_max_mag};
        end else begin
            q = {sign, exp[4:0], mant_r[9:0]};
        end
    end

endmodule

`default_nettype wire

//--- rsqrt_fp16.sv
`timescale 1ns/100ps
`default_nettype none

module rsqrt_fp16 import ln_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    input  wire fp16_t a,
    output fp16_t      q
);

    logic              odd;
    logic signed [6:0] e_even;
    logic [4:0]        rexp_in;
    logic [11:0]       x_in;

    // Operand in Q2.10, seed and Newton terms in Q1.15
    logic [11:0] x_q [1:2];
    logic [15:0] y0_q [1:4];
    logic [15:0] sq_q;
    logic [16:0] t_q;
    logic [17:0] u_q;
    logic [15:0] y1_q;
    fp16_t       res_q;
    logic        zero_q [1:6];
    logic [4:0]  rexp_q [1:5];

    logic [31:0] sq_full;
    logic [27:0] t_full;
    logic [33:0] p_full;
    fp16_t       norm;

    always_comb begin
        // Odd exponents fold a factor of two into the mantissa
        odd     = ~a.exp[0];
        e_even  = 7'(a.exp) - 7'(fp16_bias) - 7'(odd);
        rexp_in = 5'(7'(fp16_bias) - (e_even >>> 1));
        x_in    = odd ? {1'b1, a.mant, 1'b0} : {2'b01, a.mant};
    end

    ////////////////////
    // Newton step y1 = y0 * (3 - x*y0^2) / 2
    ////////////////////
    assign sq_full = y0_q[1] * y0_q[1];
    assign t_full  = x_q[2] * sq_q;
    assign p_full  = y0_q[4] * u_q;

    // Refined value lies in (0.5, 1]
    always_comb begin
        if (y1_q[15]) begin
            norm = {1'b0, rexp_q[5], y1_q[14:5]};
        end else begin
            norm = {1'b0, rexp_q[5] - 5'd1, y1_q[13:4]};
        end
    end

    always_ff @(posedge clk) begin
        x_q[1]  <= x_in;
        y0_q[1] <= rsqrt_seed[{odd, a.mant[9:6]}];
        x_q[2]  <= x_q[1];
        sq_q    <= sq_full[30:15];
        for (int i = 2; i <= 4; i++) begin
            y0_q[i] <= y0_q[i-1];
        end
        t_q     <= t_full[26:10];
        u_q     <= 18'(3 << 15) - 18'(t_q);
        y1_q    <= p_full[31:16];
        res_q   <= norm;
    end

    // Flush flag and result exponent ride alongside the data
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i <= 6; i++) begin
                zero_q[i] <= 1'b1;
            end
            for (int i = 1; i <= 5; i++) begin
                rexp_q[i] <= '0;
            end
            q <= '0;
        end else begin
            zero_q[1] <= (a.exp == '0);
            rexp_q[1] <= rexp_in;
            for (int i = 2; i <= 6; i++) begin
                zero_q[i] <= zero_q[i-1];
            end
            for (int i = 2; i <= 5; i++) begin
                rexp_q[i] <= rexp_q[i-1];
            end
            // rsqrt of zero clamps to the largest finite value
            q <= zero_q[6] ? {1'b0, fp16_max_mag} : res_q;
        end
    end

endmodule

`default_nettype wire

//--- tb_layer_norm_out.sv
`timescale 1ns/100ps
`default_nettype none

module tb_layer_norm_out import ln_pkg::*; ();

    localparam int done_timeout  = 20;
    localparam int drain_timeout = 12;

    logic                clk;
    logic                rst_n;
    logic                gamma_we;
    logic [ln_idx_w-1:0] gamma_waddr;
    fp16_t               gamma_wdata;
    logic [15:0]         sd;
    logic                sd_valid;
    logic signed [7:0]   xd;
    ln_cs_t              cs_in;
    logic                flop;
    logic                rsqrt_done;
    logic signed [7:0]   y;
    ln_cs_t              cs_out;

    integer            seed = 19761;
    int                err_count;
    int                check_count;
    int                test_count;
    int                test_err_base;
    int                cur_sd;
    string             cur_test;
    logic signed [7:0] exp_y_q [$];
    ln_cs_t            exp_cs_q [$];
    fp16_t             gamma_shadow [ln_vec_len];

    layer_norm_out u_layer_norm_out (
        .clk         (clk),
        .rst_n       (rst_n),
        .gamma_we    (gamma_we),
        .gamma_waddr (gamma_waddr),
        .gamma_wdata (gamma_wdata),
        .sd          (sd),
        .sd_valid    (sd_valid),
        .xd          (xd),
        .cs_in       (cs_in),
        .flop        (flop),
        .rsqrt_done  (rsqrt_done),
        .y           (y),
        .cs_out      (cs_out)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////
    // Reference model
    ////////////////////
    function automatic fp16_t make_gamma(input bit neg, input int k, input bit half);
        fp16_t g;
        g.sign = neg;
        g.exp  = 5'(15 + k);
        // 0x200 in the mantissa gives 1.5
        g.mant = half ? 10'h200 : 10'h000;
        return g;
    endfunction

    function automatic real gamma_value(input fp16_t g);
        real v;
        if (g.exp == '0) begin
            return 0.0;
        end
        v = 1.0 + real'(g.mant) / 1024.0;
        for (int i = 15; i < int'(g.exp); i++) begin
            v = v * 2.0;
        end
        for (int i = int'(g.exp); i < 15; i++) begin
            v = v / 2.0;
        end
        return g.sign ? -v : v;
    endfunction

    function automatic logic signed [7:0] model_y(input fp16_t g, input int sd_v,
                                                  input logic signed [7:0] xd_v);
        real v;
        int  t;
        v = gamma_value(g) * real'(xd_v) / $sqrt(real'(sd_v));
        // Truncation toward zero, then int8 clamp
        t = $rtoi(v);
        if (t > 127) begin
            t = 127;
        end else if (t < -128) begin
            t = -128;
        end
        return 8'(t);
    endfunction

    ////////////////////
    // Checks
    ////////////////////
    task automatic compare_y(input logic signed [7:0] expected, input logic signed [7:0] actual);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("MISMATCH %s y expected %0d actual %0d", cur_test, expected, actual);
        end
    endtask

    task automatic compare_cs(input ln_cs_t expected, input ln_cs_t actual);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("MISMATCH %s cs_out expected %h actual %h", cur_test, expected, actual);
        end
    endtask

    task automatic compare_done(input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("MISMATCH %s rsqrt_done expected %b actual %b", cur_test, expected, actual);
        end
    endtask

    // One clock, then match any stored result against the oldest element sent
    task automatic tick();
        logic signed [7:0] ey;
        ln_cs_t            ecs;
        @(posedge clk);
        #2;
        if (cs_out.store_y === 1'b1) begin
            if (exp_y_q.size() == 0) begin
                err_count++;
                $display("%s: a result came out with no element in flight", cur_test);
            end else begin
                ey  = exp_y_q.pop_front();
                ecs = exp_cs_q.pop_front();
                compare_y(ey, y);
                compare_cs(ecs, cs_out);
            end
        end
    endtask

    ////////////////////
    // Drivers
    ////////////////////
    task automatic write_gamma(input logic [ln_idx_w-1:0] idx, input fp16_t g);
        flop        = 1'b0;
        gamma_we    = 1'b1;
        gamma_waddr = idx;
        gamma_wdata = g;
        gamma_shadow[idx] = g;
        tick();
        gamma_we = 1'b0;
    endtask

    task automatic load_sd(input int sd_v);
        int n;
        flop     = 1'b0;
        sd       = 16'(sd_v);
        sd_valid = 1'b1;
        tick();
        sd_valid = 1'b0;
        compare_done(1'b0, rsqrt_done);
        n = 0;
        while (rsqrt_done !== 1'b1 && n < done_timeout) begin
            tick();
            n++;
        end
        if (rsqrt_done !== 1'b1) begin
            err_count++;
            $display("%s: rsqrt_done did not rise after sd_valid", cur_test);
        end
        cur_sd = sd_v;
    endtask

    task automatic send(input logic signed [7:0] xd_v, input logic [ln_idx_w-1:0] idx);
        ln_cs_t c;
        c.store_y = 1'b1;
        c.idx     = idx;
        flop      = 1'b1;
        xd        = xd_v;
        cs_in     = c;
        exp_y_q.push_back(model_y(gamma_shadow[idx], cur_sd, xd_v));
        exp_cs_q.push_back(c);
        tick();
    endtask

    // Bubbles push the pipeline until every element is out
    task automatic drain();
        int n;
        flop  = 1'b1;
        cs_in = '0;
        xd    = '0;
        n     = 0;
        while (exp_y_q.size() > 0 && n < drain_timeout) begin
            tick();
            n++;
        end
        if (exp_y_q.size() > 0) begin
            err_count++;
            $display("%s: %0d results did not come out in time", cur_test, exp_y_q.size());
            exp_y_q.delete();
            exp_cs_q.delete();
        end
        flop = 1'b0;
    endtask

    task automatic begin_test(input string name);
        cur_test      = name;
        test_err_base = err_count;
    endtask

    task automatic end_test();
        test_count++;
        if (err_count == test_err_base) begin
            $display("%-16s passed", cur_test);
        end else begin
            $display("%-16s failed with %0d errors", cur_test, err_count - test_err_base);
        end
    endtask

    ////////////////////
    // Tests
    ////////////////////
    task automatic test_reset();
        begin_test("reset");
        compare_y(8'sd0, y);
        compare_cs('0, cs_out);
        compare_done(1'b0, rsqrt_done);
        load_sd(16);
        // Second sd shows the fall from a high rsqrt_done
        load_sd(4);
        end_test();
    endtask

    task automatic test_scaling();
        int sd_list [5] = '{1, 4, 64, 1024, 16384};
        begin_test("scaling");
        write_gamma(8'd1, make_gamma(1'b0, 0, 1'b0));
        write_gamma(8'd2, make_gamma(1'b0, 0, 1'b1));
        write_gamma(8'd3, make_gamma(1'b1, -1, 1'b0));
        foreach (sd_list[i]) begin
            load_sd(sd_list[i]);
            for (int j = 0; j < 6; j++) begin
                send(8'($random(seed)), 8'(1 + j % 3));
            end
            drain();
        end
        end_test();
    endtask

    task automatic test_saturation();
        begin_test("saturation");
        load_sd(1);
        write_gamma(8'd10, make_gamma(1'b0, 6, 1'b0));
        write_gamma(8'd11, make_gamma(1'b1, 6, 1'b0));
        send(8'sd127, 8'd10);
        send(-8'sd128, 8'd10);
        send(8'sd2, 8'd10);
        send(-8'sd2, 8'd11);
        send(8'sd127, 8'd11);
        send(-8'sd1, 8'd11);
        drain();
        end_test();
    endtask

    task automatic test_gamma_table();
        begin_test("gamma_table");
        load_sd(4);
        write_gamma(8'd20, make_gamma(1'b0, -1, 1'b0));
        write_gamma(8'd21, make_gamma(1'b1, 2, 1'b0));
        send(-8'sd100, 8'd20);
        send(8'sd30, 8'd21);
        drain();
        // Element in flight keeps the old entry
        send(8'sd50, 8'd20);
        write_gamma(8'd20, make_gamma(1'b0, 0, 1'b1));
        send(8'sd50, 8'd20);
        drain();
        end_test();
    endtask

    task automatic test_alignment();
        begin_test("alignment");
        load_sd(64);
        write_gamma(8'd40, make_gamma(1'b0, 2, 1'b0));
        write_gamma(8'd41, make_gamma(1'b1, 1, 1'b0));
        write_gamma(8'd42, make_gamma(1'b0, 1, 1'b1));
        send(8'($random(seed)), 8'd40);
        send(8'($random(seed)), 8'd41);
        send(8'($random(seed)), 8'd42);
        drain();
        end_test();
    endtask

    task automatic test_backpressure();
        logic signed [7:0] y_hold;
        begin_test("backpressure");
        load_sd(256);
        write_gamma(8'd50, make_gamma(1'b0, 4, 1'b0));
        write_gamma(8'd51, make_gamma(1'b1, 5, 1'b0));
        write_gamma(8'd52, make_gamma(1'b0, 3, 1'b1));
        send(8'sd45, 8'd50);
        send(-8'sd37, 8'd51);
        send(8'sd90, 8'd52);
        flop   = 1'b0;
        y_hold = y;
        repeat (4) begin
            tick();
            compare_y(y_hold, y);
            compare_cs('0, cs_out);
        end
        drain();
        end_test();
    endtask

    initial begin
        rst_n       = 1'b0;
        gamma_we    = 1'b0;
        gamma_waddr = '0;
        gamma_wdata = '0;
        sd          = '0;
        sd_valid    = 1'b0;
        xd          = '0;
        cs_in       = '0;
        flop        = 1'b0;
        err_count   = 0;
        check_count = 0;
        test_count  = 0;
        cur_sd      = 1;
        cur_test    = "init";
        foreach (gamma_shadow[i]) begin
            gamma_shadow[i] = '0;
        end
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;

        test_reset();
        test_scaling();
        test_saturation();
        test_gamma_table();
        test_alignment();
        test_backpressure();

        $display("Tests run: %0d, checks: %0d, errors: %0d", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
ln_pkg.sv
int_to_fp16.sv
mult_fp16.sv
rsqrt_fp16.sv
fp16_to_int_sat.sv
count_down.sv
gamma_table.sv
gamma_path.sv
layer_norm_out.sv
layer_norm_properties.sv
tb_layer_norm_out.sv
